// ==== tb.f ====
+incdir+include
rtl/blur_pkg.sv
rtl/gaussian.sv
rtl/gaussian_wrapper.sv
rtl/image_buffers.sv
rtl/blur_csr.sv
rtl/blur_top.sv
dv/blur_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the blur testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  --top-module blur_tb -f tb.f --Mdir "$BUILD_DIR" -o blur_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/blur_sim" > "$LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
  exit 1
fi
exit 0

// ==== dv/blur_tb.sv ====
// blur accelerator testbench
`timescale 1ns/10ps
`default_nettype none

`include "blur_config.svh"

module blur_tb
  import blur_pkg::*;
();

  localparam int TOTAL_ROWS      = 64 + 1 + 2 + 64 + 24 + 37; // rows over all runs
  localparam int WATCHDOG_CYCLES = TOTAL_ROWS * 200 + 2000;

  logic       clk;
  logic       reset;
  axi_addr_t  aw_addr;
  logic       aw_valid;
  logic       aw_ready;
  axi_data_t  w_data;
  logic [3:0] w_strb;
  logic       w_valid;
  logic       w_ready;
  axi_resp_t  b_resp;
  logic       b_valid;
  logic       b_ready;
  axi_addr_t  ar_addr;
  logic       ar_valid;
  logic       ar_ready;
  axi_data_t  r_data;
  axi_resp_t  r_resp;
  logic       r_valid;
  logic       r_ready;

  int   error_count;
  int   check_count;
  row_t image       [`BLUR_MAX_ROWS];
  row_t expect_rows [`BLUR_MAX_ROWS];

  blur_top i_blur_top (
    .clk      (clk),
    .reset    (reset),
    .aw_addr  (aw_addr),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w_data   (w_data),
    .w_strb   (w_strb),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b_resp   (b_resp),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .ar_addr  (ar_addr),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r_data   (r_data),
    .r_resp   (r_resp),
    .r_valid  (r_valid),
    .r_ready  (r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  // ****************************************
  // checking helpers
  // ****************************************
  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic int clamp(int v, int hi);
    if (v < 0) return 0;
    if (v > hi) return hi;
    return v;
  endfunction

  // kernel 1 2 1 / 2 4 2 / 1 2 1 on replicated edges
  function automatic pixel_t filter_ref(int r, int c, int n);
    int sum;
    int w;
    sum = 8; // round half up
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        w = (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1);
        sum += w * image[clamp(r + dr, n - 1)][clamp(c + dc, `BLUR_PIXELS - 1)];
      end
    end
    return pixel_t'(sum >> 4);
  endfunction

  // ****************************************
  // axi4-lite host
  // ****************************************
  task automatic write_word(input axi_addr_t addr, input axi_data_t data,
                            output axi_resp_t resp);
    @(negedge clk);
    aw_addr  = addr;
    w_data   = data;
    w_strb   = 4'hf;
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    @(negedge clk);
    while (!aw_ready) @(negedge clk);
    @(negedge clk); // transfer on the edge just passed
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    b_ready  = 1'b1;
    while (!b_valid) @(negedge clk);
    resp = b_resp;
    @(negedge clk);
    b_ready = 1'b0;
  endtask

  task automatic read_word(input axi_addr_t addr, output axi_data_t data,
                           output axi_resp_t resp);
    @(negedge clk);
    ar_addr  = addr;
    ar_valid = 1'b1;
    @(negedge clk);
    while (!ar_ready) @(negedge clk);
    @(negedge clk);
    ar_valid = 1'b0;
    r_ready  = 1'b1;
    while (!r_valid) @(negedge clk);
    data = r_data;
    resp = r_resp;
    @(negedge clk);
    r_ready = 1'b0;
  endtask

  task automatic write_checked(input axi_addr_t addr, input axi_data_t data);
    axi_resp_t resp;
    write_word(addr, data, resp);
    compare("b_resp", resp, OKAY);
  endtask

  task automatic expect_read(input axi_addr_t addr, input axi_data_t exp, input string name);
    axi_data_t data;
    axi_resp_t resp;
    read_word(addr, data, resp);
    compare("r_resp", resp, OKAY);
    compare(name, data, exp);
  endtask

  // ****************************************
  // image runs
  // ****************************************
  task automatic prepare_image(input int n);
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < `BLUR_PIXELS; c++) begin
        image[r][c] = pixel_t'($urandom);
      end
    end
    for (int r = 0; r < n; r++) begin
      write_checked(axi_addr_t'(`BLUR_WIN_IN + 8 * r), image[r][3:0]);
      write_checked(axi_addr_t'(`BLUR_WIN_IN + 8 * r + 4), image[r][7:4]);
      for (int c = 0; c < `BLUR_PIXELS; c++) begin
        expect_rows[r][c] = filter_ref(r, c, n);
      end
    end
  endtask

  task automatic start_run(input int n);
    write_checked(`BLUR_REG_ROWS, axi_data_t'(n));
    write_checked(`BLUR_REG_CTRL, 32'h1);
  endtask

  task automatic wait_finish(input int n);
    axi_data_t status;
    axi_resp_t resp;
    int        polls;
    polls  = 0;
    status = '0;
    while (!status[0] && polls < n * 50 + 20) begin
      read_word(`BLUR_REG_STATUS, status, resp);
      polls++;
    end
    assert (status[0]) else begin
      error_count++;
      $display("finish never rose for the %0d-row image after %0d status reads", n, polls);
    end
    compare("status", status, 32'h1); // finish set, busy clear
  endtask

  task automatic check_output(input int n);
    for (int r = 0; r < n; r++) begin
      expect_read(axi_addr_t'(`BLUR_WIN_OUT + 8 * r), expect_rows[r][3:0],
                  $sformatf("r_data out row %0d low", r));
      expect_read(axi_addr_t'(`BLUR_WIN_OUT + 8 * r + 4), expect_rows[r][7:4],
                  $sformatf("r_data out row %0d high", r));
    end
  endtask

  task automatic run_image(input int n);
    prepare_image(n);
    start_run(n);
    wait_finish(n);
    check_output(n);
  endtask

  // ****************************************
  // test sequence
  // ****************************************
  initial begin
    axi_data_t data;
    axi_resp_t resp;
    void'($urandom(92));
    error_count = 0;
    check_count = 0;
    reset    = 1'b1;
    aw_addr  = '0;
    aw_valid = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar_addr  = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    expect_read(`BLUR_REG_STATUS, 32'h0, "r_data status");
    write_checked(`BLUR_REG_ROWS, 32'd24);
    expect_read(`BLUR_REG_ROWS, 32'd24, "r_data rows");

    run_image(64);
    run_image(1);
    run_image(2);

    // host reads of the input window stall the sequencer
    prepare_image(64);
    start_run(64);
    read_word(`BLUR_REG_STATUS, data, resp);
    compare("busy", data[1], 1'b1);
    for (int i = 0; i < 16; i++) begin
      expect_read(axi_addr_t'(`BLUR_WIN_IN + 4 * i),
                  i[0] ? image[i / 2][7:4] : image[i / 2][3:0], "r_data in window");
    end
    wait_finish(64);
    check_output(64);

    prepare_image(24);
    start_run(24);
    read_word(`BLUR_REG_STATUS, data, resp);
    compare("busy", data[1], 1'b1);
    write_checked(`BLUR_REG_ROWS, 32'd10); // a restart would pick this up
    write_checked(`BLUR_REG_CTRL, 32'h1); // start while busy
    wait_finish(24);
    check_output(24);
    prepare_image(37);
    start_run(37);
    read_word(`BLUR_REG_STATUS, data, resp);
    compare("finish", data[0], 1'b0);
    wait_finish(37);
    check_output(37);

    // unmapped space
    write_word(12'h00c, 32'h5, resp);
    compare("b_resp", resp, SLVERR);
    write_word(12'hc08, 32'h12345678, resp);
    compare("b_resp", resp, SLVERR);
    write_word(`BLUR_WIN_OUT, 32'hdeadbeef, resp);
    compare("b_resp", resp, SLVERR);
    expect_read(`BLUR_REG_ROWS, 32'd37, "r_data rows");
    expect_read(`BLUR_WIN_OUT, expect_rows[0][3:0], "r_data out row 0 low");
    read_word(12'h00c, data, resp);
    compare("r_resp", resp, SLVERR);
    compare("r_data", data, 32'h0);
    read_word(12'h204, data, resp);
    compare("r_resp", resp, SLVERR);
    compare("r_data", data, 32'h0);

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : blur_tb

`default_nettype wire

// ==== rtl/blur_top.sv ====
// gaussian blur accelerator top
`timescale 1ns/10ps
`default_nettype none

module blur_top
  import blur_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  // axi4-lite slave
  input  axi_addr_t  aw_addr,
  input  logic       aw_valid,
  output logic       aw_ready,
  input  axi_data_t  w_data,
  input  logic [3:0] w_strb,
  input  logic       w_valid,
  output logic       w_ready,
  output axi_resp_t  b_resp,
  output logic       b_valid,
  input  logic       b_ready,
  input  axi_addr_t  ar_addr,
  input  logic       ar_valid,
  output logic       ar_ready,
  output axi_data_t  r_data,
  output axi_resp_t  r_resp,
  output logic       r_valid,
  input  logic       r_ready
);

  // ****************************************
  // host port and run control
  // ****************************************
  logic      host_req;
  logic      host_we;
  logic      host_hi;
  row_idx_t  host_row;
  axi_data_t host_wdata;
  axi_data_t host_rdata;
  row_idx_t  out_host_row;
  row_t      out_host_rdata;
  logic      start;
  row_cnt_t  num_rows;
  logic      busy;
  logic      finish;

  // wrapper side of the buffers
  logic      rd_req;
  row_idx_t  rd_row;
  logic      rd_full;
  logic      rd_valid;
  row_t      rd_data;
  logic      wr_en;
  row_idx_t  wr_row;
  row_t      wr_data;

  blur_csr u_csr (.*);

  image_buffers u_buffers (.*);

  gaussian_wrapper u_wrapper (.*);

endmodule : blur_top

`default_nettype wire

// ==== rtl/blur_csr.sv ====
// axi4-lite control and status
`timescale 1ns/10ps
`default_nettype none

`include "blur_config.svh"

module blur_csr
  import blur_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  axi_addr_t  aw_addr,
  input  logic       aw_valid,
  output logic       aw_ready,
  input  axi_data_t  w_data,
  input  logic [3:0] w_strb,
  input  logic       w_valid,
  output logic       w_ready,
  output axi_resp_t  b_resp,
  output logic       b_valid,
  input  logic       b_ready,
  input  axi_addr_t  ar_addr,
  input  logic       ar_valid,
  output logic       ar_ready,
  output axi_data_t  r_data,
  output axi_resp_t  r_resp,
  output logic       r_valid,
  input  logic       r_ready,
  output logic       host_req,
  output logic       host_we,
  output logic       host_hi,
  output row_idx_t   host_row,
  output axi_data_t  host_wdata,
  input  axi_data_t  host_rdata,
  output row_idx_t   out_host_row,
  input  row_t       out_host_rdata,
  output logic       start,
  output row_cnt_t   num_rows,
  input  logic       busy,
  input  logic       finish
);

  localparam int WIN_AW = `BLUR_ROW_AW + 3; // 8 bytes per row
  localparam int HALF   = `BLUR_PIXELS / 2;

  logic     wr_fire;
  logic     rd_fire;
  logic     wr_accept;
  logic     rd_accept;
  logic     wr_in_win;
  logic     rd_in_win;
  logic     rd_out_win;
  logic     wr_full;    // all byte lanes
  logic     rd_pend;    // waiting one cycle on memory
  logic     rd_from_out;
  logic     rd_hi;
  row_cnt_t wr_rows;

  function automatic logic in_window(axi_addr_t addr, axi_addr_t base);
    return addr[11:WIN_AW] == base[11:WIN_AW];
  endfunction

  assign wr_fire    = aw_valid & aw_ready & w_valid & w_ready;
  assign rd_fire    = ar_valid & ar_ready;
  assign wr_in_win  = in_window(aw_addr, `BLUR_WIN_IN);
  assign rd_in_win  = in_window(ar_addr, `BLUR_WIN_IN);
  assign rd_out_win = in_window(ar_addr, `BLUR_WIN_OUT);
  assign wr_full    = &w_strb;
  assign wr_rows    = w_data[`BLUR_ROW_AW:0];

  // writes go first when both channels knock
  assign wr_accept = aw_valid & w_valid & ~aw_ready & ~b_valid;
  assign rd_accept = ar_valid & ~ar_ready & ~r_valid & ~rd_pend & ~wr_accept;

  // ****************************************
  // buffer host port
  // ****************************************
  assign host_req     = (wr_fire & wr_in_win & wr_full) | (rd_fire & rd_in_win);
  assign host_we      = wr_fire;
  assign host_hi      = wr_fire ? aw_addr[2] : ar_addr[2];
  assign host_row     = wr_fire ? aw_addr[WIN_AW-1:3] : ar_addr[WIN_AW-1:3];
  assign host_wdata   = w_data;
  assign out_host_row = ar_addr[WIN_AW-1:3];

  // ****************************************
  // write channel
  // ****************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      b_valid  <= 1'b0;
      b_resp   <= OKAY;
      start    <= 1'b0;
      num_rows <= row_cnt_t'(`BLUR_MAX_ROWS);
    end else begin
      aw_ready <= wr_accept;
      w_ready  <= wr_accept;
      start    <= 1'b0;
      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
      if (wr_fire) begin
        b_valid <= 1'b1;
        b_resp  <= OKAY;
        if (aw_addr == `BLUR_REG_CTRL) begin
          start <= w_strb[0] & w_data[0]; // one-cycle pulse
        end else if (aw_addr == `BLUR_REG_ROWS) begin
          if (w_strb[0] && wr_rows != '0 && wr_rows <= `BLUR_MAX_ROWS) begin
            num_rows <= wr_rows;
          end
        end else if (wr_in_win) begin
          if (!wr_full) begin
            b_resp <= SLVERR; // no partial row writes
          end
        end else if (aw_addr != `BLUR_REG_STATUS) begin
          b_resp <= SLVERR;
        end
      end
    end
  end

  // ****************************************
  // read channel
  // ****************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ar_ready    <= 1'b0;
      r_valid     <= 1'b0;
      r_resp      <= OKAY;
      r_data      <= '0;
      rd_pend     <= 1'b0;
      rd_from_out <= 1'b0;
      rd_hi       <= 1'b0;
    end else begin
      ar_ready <= rd_accept;
      if (r_valid && r_ready) begin
        r_valid <= 1'b0;
      end
      if (rd_fire) begin
        r_resp <= OKAY;
        if (rd_in_win || rd_out_win) begin
          rd_pend     <= 1'b1;
          rd_from_out <= rd_out_win;
          rd_hi       <= ar_addr[2];
        end else begin
          r_valid <= 1'b1;
          case (ar_addr)
            `BLUR_REG_CTRL:   r_data <= '0;
            `BLUR_REG_STATUS: r_data <= {30'd0, busy, finish};
            `BLUR_REG_ROWS:   r_data <= axi_data_t'(num_rows);
            default: begin
              r_data <= '0;
              r_resp <= SLVERR;
            end
          endcase
        end
      end
      if (rd_pend) begin
        rd_pend <= 1'b0;
        r_valid <= 1'b1;
        if (rd_from_out) begin
          r_data <= rd_hi ? out_host_rdata[HALF +: HALF] : out_host_rdata[0 +: HALF];
        end else begin
          r_data <= host_rdata;
        end
      end
    end
  end

endmodule : blur_csr

`default_nettype wire

// ==== rtl/image_buffers.sv ====
// input and output image memories
`timescale 1ns/10ps
`default_nettype none

`include "blur_config.svh"

module image_buffers
  import blur_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      host_req,
  input  logic      host_we,
  input  logic      host_hi,
  input  row_idx_t  host_row,
  input  axi_data_t host_wdata,
  output axi_data_t host_rdata,
  input  row_idx_t  out_host_row,
  output row_t      out_host_rdata,
  input  logic      rd_req,
  input  row_idx_t  rd_row,
  output logic      rd_full,
  output logic      rd_valid,
  output row_t      rd_data,
  input  logic      wr_en,
  input  row_idx_t  wr_row,
  input  row_t      wr_data
);

  localparam int HALF = `BLUR_PIXELS / 2;

  row_t     in_mem  [`BLUR_MAX_ROWS];
  row_t     out_mem [`BLUR_MAX_ROWS];
  row_t     in_q;      // read register of the shared port
  row_idx_t port_row;
  logic     port_rd;
  logic     hi_q;

  // ****************************************
  // input memory, host has priority
  // ****************************************
  assign rd_full  = host_req;
  assign port_row = host_req ? host_row : rd_row;
  assign port_rd  = host_req ? ~host_we : rd_req;

  always_ff @(posedge clk) begin
    if (host_req && host_we) begin
      if (host_hi) begin
        in_mem[port_row][HALF +: HALF] <= host_wdata;
      end else begin
        in_mem[port_row][0 +: HALF] <= host_wdata;
      end
    end
    if (port_rd) begin
      in_q <= in_mem[port_row];
    end
    hi_q <= host_hi;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_req & ~host_req; // stalled request returns nothing
    end
  end

  assign rd_data    = in_q;
  assign host_rdata = hi_q ? in_q[HALF +: HALF] : in_q[0 +: HALF];

  // ****************************************
  // output memory
  // ****************************************
  always_ff @(posedge clk) begin
    if (wr_en) begin
      out_mem[wr_row] <= wr_data;
    end
    out_host_rdata <= out_mem[out_host_row];
  end

endmodule : image_buffers

`default_nettype wire

// ==== rtl/gaussian_wrapper.sv ====
// gaussian row sequencer
`timescale 1ns/10ps
`default_nettype none

module gaussian_wrapper
  import blur_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     start,
  input  row_cnt_t num_rows,
  output logic     busy,
  output logic     finish,
  output logic     rd_req,
  output row_idx_t rd_row,
  input  logic     rd_full,
  input  logic     rd_valid,
  input  row_t     rd_data,
  output logic     wr_en,
  output row_idx_t wr_row,
  output row_t     wr_data
);

  typedef enum logic [1:0] {START, RUN, FINISH} wrapper_state_t;

  wrapper_state_t state;
  row_idx_t       read_offset;
  row_idx_t       count_write;
  row_idx_t       last_row;   // latched at start
  logic           rd_accept;
  logic           rd_last;
  logic           resp_last;  // last mark beside the buffer response
  logic           wr_done;
  logic           valid_in;
  logic           last_in;
  row_t           data_in;
  logic           valid_out;
  row_t           data_out;

  gaussian u_gaussian (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (valid_in),
    .last_in   (last_in),
    .data_in   (data_in),
    .valid_out (valid_out),
    .data_out  (data_out)
  );

  // ****************************************
  // read sequencer
  // ****************************************
  assign rd_req    = (state == RUN);
  assign rd_row    = read_offset;
  assign rd_accept = rd_req & ~rd_full;
  assign rd_last   = (read_offset == last_row);
  assign busy      = (state != START);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= START;
      read_offset <= '0;
      last_row    <= '0;
    end else begin
      case (state)
        START: begin
          if (start) begin
            read_offset <= '0;
            last_row    <= row_idx_t'(num_rows - 1'b1);
            state       <= RUN;
          end
        end
        RUN: begin
          if (rd_accept) begin
            read_offset <= read_offset + 1'b1;
            if (rd_last) begin
              state <= FINISH;
            end
          end
        end
        FINISH: begin
          if (wr_done) begin
            state <= START;
          end
        end
        default: state <= START;
      endcase
    end
  end

  // response registered once more
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      resp_last <= 1'b0;
      valid_in  <= 1'b0;
      last_in   <= 1'b0;
    end else begin
      resp_last <= rd_accept & rd_last;
      valid_in  <= rd_valid;
      last_in   <= rd_valid & resp_last;
    end
  end

  always_ff @(posedge clk) begin
    data_in <= rd_data;
  end

  // ****************************************
  // output rows and finish
  // ****************************************
  assign wr_en   = valid_out;
  assign wr_row  = count_write;
  assign wr_data = data_out;
  assign wr_done = valid_out & (count_write == last_row) & (state == FINISH);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      finish      <= 1'b0;
      count_write <= '0;
    end else if (state == START && start) begin
      finish      <= 1'b0;
      count_write <= '0;
    end else begin
      finish      <= finish | wr_done; // sticky
      count_write <= count_write + valid_out;
    end
  end

endmodule : gaussian_wrapper

`default_nettype wire

// ==== rtl/gaussian.sv ====
// 3x3 gaussian row filter
`timescale 1ns/10ps
`default_nettype none

`include "blur_config.svh"

module gaussian
  import blur_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic valid_in,
  input  logic last_in,
  input  row_t data_in,
  output logic valid_out,
  output row_t data_out
);

  localparam int N = `BLUR_PIXELS;

  row_t prev_row;   // upper neighbor of cur_row
  row_t cur_row;
  logic cur_valid;
  logic flush;      // last row still to be emitted
  logic emit;
  row_t lower_row;

  // ****************************************
  // kernel 1 2 1 / 2 4 2 / 1 2 1
  // ****************************************

  // horizontal pass, columns clamped at both ends
  function automatic logic [9:0] h_sum(row_t row, int c);
    int l;
    int r;
    l = (c == 0) ? 0 : c - 1;
    r = (c == N - 1) ? N - 1 : c + 1;
    return {2'b00, row[l]} + {1'b0, row[c], 1'b0} + {2'b00, row[r]};
  endfunction

  function automatic row_t blur(row_t up, row_t mid, row_t dn);
    row_t        res;
    logic [11:0] sum;
    for (int c = 0; c < N; c++) begin
      sum = {2'b00, h_sum(up, c)} + {1'b0, h_sum(mid, c), 1'b0} + {2'b00, h_sum(dn, c)};
      sum = sum + 12'd8; // round half up
      res[c] = sum[11:4];
    end
    return res;
  endfunction

  // ****************************************
  // row window
  // ****************************************
  assign emit      = flush | (valid_in & cur_valid);
  assign lower_row = flush ? cur_row : data_in; // last row clamps below

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cur_valid <= 1'b0;
      flush     <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      valid_out <= emit;
      flush     <= valid_in & last_in;
      if (valid_in) begin
        cur_valid <= 1'b1;
      end else if (flush) begin
        cur_valid <= 1'b0; // back to expecting a first row
      end
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      data_out <= blur(prev_row, cur_row, lower_row);
    end
    if (valid_in) begin
      // first row is its own upper neighbor
      prev_row <= (cur_valid && !flush) ? cur_row : data_in;
      cur_row  <= data_in;
    end
  end

endmodule : gaussian

`default_nettype wire

// ==== rtl/blur_pkg.sv ====
// blur accelerator shared types
`default_nettype none

`include "blur_config.svh"

package blur_pkg;

  typedef logic [`BLUR_PIXEL_W-1:0] pixel_t;
  typedef pixel_t [`BLUR_PIXELS-1:0] row_t;   // pixel 0 in the low byte

  typedef logic [`BLUR_ROW_AW-1:0] row_idx_t;
  typedef logic [`BLUR_ROW_AW:0]   row_cnt_t; // up to 64 rows

  typedef logic [11:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_t;

endpackage : blur_pkg

`default_nettype wire

// ==== include/blur_config.svh ====
// blur accelerator configuration
`ifndef BLUR_CONFIG_SVH
`define BLUR_CONFIG_SVH

// image geometry
`define BLUR_PIXELS    8
`define BLUR_PIXEL_W   8
`define BLUR_MAX_ROWS  64
`define BLUR_ROW_AW    6

// axi4-lite register map
`define BLUR_REG_CTRL   12'h000
`define BLUR_REG_STATUS 12'h004
`define BLUR_REG_ROWS   12'h008
`define BLUR_WIN_IN     12'h400 // input rows, 8 bytes each
`define BLUR_WIN_OUT    12'h800 // filtered rows, read only

`endif
